/* Bender.yml */
package:
  name: uart_periph

sources:
  - files:
      - common/uart_pkg.sv
      - common/uart_tx_if.sv
      - uart/uart_rx_fifo.sv
      - uart/uart_rx.sv
      - uart/uart_tx.sv
      - uart/uart_regs.sv
      - source/uart_top.sv
  - target: test
    files:
      - tb/uart_top_sva.sv
      - tb/tb_uart_top.sv

/* common/uart_pkg.sv */
// ------------------------------
// UART package
// Widths, register map, status bits and FSM states
// ------------------------------
`default_nettype none

package uart_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int XLEN     = 32;
    localparam int BYTE_W   = 8;
    localparam int BAUD_W   = 16;
    localparam int IDX_W    = 4;
    localparam int STATUS_W = 4;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [BYTE_W-1:0] uart_byte_t;
    typedef logic [BAUD_W-1:0] baud_div_t;
    typedef logic [IDX_W-1:0]  reg_idx_t;

    // Word index of each register, from address bits 5 to 2
    localparam reg_idx_t UART_TXDATA_R   = 4'd0;
    localparam reg_idx_t UART_RXDATA_R   = 4'd1;
    localparam reg_idx_t UART_BAUD_R     = 4'd2;
    localparam reg_idx_t UART_STATUS_R   = 4'd3;
    localparam reg_idx_t UART_TXCTRL_R   = 4'd4;
    localparam reg_idx_t UART_RXCTRL_R   = 4'd5;
    localparam reg_idx_t UART_INT_MASK_R = 4'd6;

    // Status register bit positions
    localparam int ST_TX_READY  = 0;
    localparam int ST_RX_AVAIL  = 1;
    localparam int ST_FRAME_ERR = 2;
    localparam int ST_RX_OVFL   = 3;

    localparam baud_div_t BAUD_RESET = 16'd16;

    // Receive FIFO geometry
    localparam int RX_FIFO_DEPTH = 8;
    localparam int RX_FIFO_AW    = $clog2(RX_FIFO_DEPTH);

    // ------------------------------
    // Serial FSM states
    // ------------------------------
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

`default_nettype wire

/* common/uart_tx_if.sv */
// ------------------------------
// Transmit side interface
// Byte strobe, ready and line settings
// ------------------------------
`default_nettype none

interface uart_tx_if;
    import uart_pkg::*;

    uart_byte_t tx_data;
    logic       tx_valid;
    logic       tx_ready;
    baud_div_t  baud_div;
    logic       two_stop;

    // Register block side
    modport ctrl (output tx_data, output tx_valid, output baud_div, output two_stop,
                  input tx_ready);

    // Serializer side
    modport ser (input tx_data, input tx_valid, input baud_div, input two_stop,
                 output tx_ready);

endinterface

`default_nettype wire

/* source/uart_top.sv */
// ------------------------------
// UART top level
// Register block, serializer, receiver and RX FIFO
// ------------------------------
`default_nettype none

module uart_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             bus_req_i,
    input  logic             bus_we_i,
    input  logic [5:0]       bus_addr_i,
    input  uart_pkg::xlen_t  bus_wdata_i,
    input  logic             uart_sel_i,
    output uart_pkg::xlen_t  bus_rdata_o,
    output logic             bus_ack_o,
    output logic             uart_irq_o,
    output logic             uart_txd_o,
    input  logic             uart_rxd_i
);
    import uart_pkg::*;

    uart_byte_t  rx_data;
    logic        rx_valid;
    logic        frame_err;
    logic        fifo_push;
    uart_byte_t  fifo_push_data;
    logic        fifo_pop;
    uart_byte_t  fifo_head;
    logic        fifo_empty;
    logic        fifo_ovfl;

    uart_tx_if tx_if ();

    uart_regs uart_regs_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .bus_req_i        (bus_req_i),
        .bus_we_i         (bus_we_i),
        .bus_addr_i       (bus_addr_i),
        .bus_wdata_i      (bus_wdata_i),
        .uart_sel_i       (uart_sel_i),
        .bus_rdata_o      (bus_rdata_o),
        .bus_ack_o        (bus_ack_o),
        .tx_if            (tx_if.ctrl),
        .rx_data_i        (rx_data),
        .rx_valid_i       (rx_valid),
        .frame_err_i      (frame_err),
        .fifo_push_o      (fifo_push),
        .fifo_push_data_o (fifo_push_data),
        .fifo_pop_o       (fifo_pop),
        .fifo_head_i      (fifo_head),
        .fifo_empty_i     (fifo_empty),
        .fifo_ovfl_i      (fifo_ovfl),
        .uart_irq_o       (uart_irq_o)
    );

    uart_tx uart_tx_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .tx_if (tx_if.ser),
        .txd_o (uart_txd_o)
    );

    // Receiver shares the programmed divisor with the transmitter
    uart_rx uart_rx_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxd_i       (uart_rxd_i),
        .baud_div_i  (tx_if.baud_div),
        .rx_data_o   (rx_data),
        .rx_valid_o  (rx_valid),
        .frame_err_o (frame_err)
    );

    uart_rx_fifo uart_rx_fifo_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (fifo_push),
        .push_data_i (fifo_push_data),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .empty_o     (fifo_empty),
        .ovfl_o      (fifo_ovfl)
    );

endmodule

`default_nettype wire

/* tb/tb_uart_top.sv */
// ------------------------------
// UART testbench
// Random bus traffic and serial frames
// checked against a queue-based model
// ------------------------------
`default_nettype none

module tb_uart_top;
    timeunit 1ns;
    timeprecision 100ps;
    import uart_pkg::*;

    localparam int TIMEOUT_CYC = 4000;

    logic        clk;
    logic        rst_n;
    logic        bus_req;
    logic        bus_we;
    logic [5:0]  bus_addr;
    xlen_t       bus_wdata;
    logic        uart_sel;
    xlen_t       bus_rdata;
    logic        bus_ack;
    logic        uart_irq;
    logic        uart_txd;
    logic        uart_rxd;

    // Model state
    int unsigned cur_div;
    logic        cur_two_stop;
    uart_byte_t  exp_tx[$];
    uart_byte_t  exp_rx[$];
    uart_byte_t  got_byte;
    uart_byte_t  tx_byte;
    uart_byte_t  rx_byte;
    xlen_t       rdata;

    uart_top uart_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req_i   (bus_req),
        .bus_we_i    (bus_we),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .uart_sel_i  (uart_sel),
        .bus_rdata_o (bus_rdata),
        .bus_ack_o   (bus_ack),
        .uart_irq_o  (uart_irq),
        .uart_txd_o  (uart_txd),
        .uart_rxd_i  (uart_rxd)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    // ------------------------------
    // Error handling and checks
    // ------------------------------
    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input xlen_t got, input xlen_t exp, input string what);
        string line;
        line = $sformatf("[FAIL] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        assert (got === exp) else begin
            abort_run(line);
        end
    endtask

    // Stop at the first failure of a bound assertion
    always @(negedge clk) begin
        if (uart_top_inst.uart_top_sva_inst.fail_cnt != 0) begin
            abort_run("A bound assertion on the UART failed");
        end
    end

    // ------------------------------
    // Bus driver
    // ------------------------------
    task automatic bus_access(input logic we, input reg_idx_t idx, input xlen_t wdata,
                              output xlen_t data);
        int unsigned waited;
        bus_req   = 1'b1;
        bus_we    = we;
        bus_addr  = {idx, 2'b00};
        bus_wdata = wdata;
        uart_sel  = 1'b1;
        waited    = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 20) begin
                abort_run("Timeout: the bus acknowledge never arrived");
            end
        end while (!bus_ack);
        data     = bus_rdata;
        bus_req  = 1'b0;
        bus_we   = 1'b0;
        uart_sel = 1'b0;
        check_value(waited, 1, "ack latency in cycles");
        // Bus stays idle for the ack cycle so the next request is a new access
        @(negedge clk);
    endtask

    task automatic reg_write(input reg_idx_t idx, input xlen_t wdata);
        xlen_t unused;
        bus_access(1'b1, idx, wdata, unused);
    endtask

    task automatic reg_read(input reg_idx_t idx, output xlen_t data);
        bus_access(1'b0, idx, '0, data);
    endtask

    // Poll status until the given bit reaches the given level
    task automatic wait_status_bit(input int bit_idx, input logic level);
        xlen_t st;
        int unsigned polls;
        polls = 0;
        reg_read(UART_STATUS_R, st);
        while (st[bit_idx] !== level) begin
            polls++;
            if (polls > TIMEOUT_CYC) begin
                abort_run("Timeout: status bit never reached the expected level");
            end
            reg_read(UART_STATUS_R, st);
        end
    endtask

    task automatic wait_irq(input logic level);
        int unsigned waited;
        waited = 0;
        while (uart_irq !== level) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYC) begin
                abort_run("Timeout: the interrupt line never changed");
            end
        end
    endtask

    // ------------------------------
    // Serial line model
    // ------------------------------
    task automatic decode_txd_frame(output uart_byte_t data);
        int unsigned waited;
        waited = 0;
        while (uart_txd !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYC) begin
                abort_run("Timeout: no start bit appeared on the TX line");
            end
        end
        // Move to the middle of the start bit
        repeat (cur_div / 2) @(negedge clk);
        check_value(uart_txd, 0, "TX start bit");
        for (int i = 0; i < 8; i++) begin
            repeat (cur_div) @(negedge clk);
            data[i] = uart_txd;
        end
        repeat (cur_div) @(negedge clk);
        check_value(uart_txd, 1, "TX first stop bit");
        if (cur_two_stop) begin
            repeat (cur_div) @(negedge clk);
            check_value(uart_txd, 1, "TX second stop bit");
        end
    endtask

    task automatic send_rx_frame(input uart_byte_t data, input logic stop_level);
        uart_rxd = 1'b0;
        repeat (cur_div) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            uart_rxd = data[i];
            repeat (cur_div) @(negedge clk);
        end
        uart_rxd = stop_level;
        repeat (cur_div) @(negedge clk);
        // One idle bit between frames
        uart_rxd = 1'b1;
        repeat (cur_div) @(negedge clk);
    endtask

    // Read back every expected RX byte, then expect an empty FIFO
    task automatic drain_rx_fifo();
        xlen_t data;
        wait_status_bit(ST_RX_AVAIL, 1'b1);
        while (exp_rx.size() > 0) begin
            reg_read(UART_RXDATA_R, data);
            check_value(data[31], 0, "RXDATA empty flag");
            check_value(data[7:0], exp_rx.pop_front(), "RX byte");
        end
        reg_read(UART_RXDATA_R, data);
        check_value(data[31], 1, "RXDATA empty flag after draining");
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        void'($urandom(32'hdd20));
        rst_n     = 1'b0;
        bus_req   = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        uart_sel  = 1'b0;
        uart_rxd  = 1'b1;
        cur_div      = 16;
        cur_two_stop = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Reset values
        check_value(uart_txd, 1, "txd after reset");
        check_value(uart_irq, 0, "irq after reset");
        reg_read(UART_BAUD_R, rdata);
        check_value(rdata, 16, "BAUD after reset");
        reg_read(UART_TXCTRL_R, rdata);
        check_value(rdata, 0, "TXCTRL after reset");
        reg_read(UART_RXCTRL_R, rdata);
        check_value(rdata, 0, "RXCTRL after reset");
        reg_read(UART_INT_MASK_R, rdata);
        check_value(rdata, 0, "INT_MASK after reset");
        reg_read(UART_STATUS_R, rdata);
        check_value(rdata, 32'h1, "STATUS after reset");
        reg_read(UART_RXDATA_R, rdata);
        check_value(rdata[31], 1, "RXDATA empty flag after reset");
        reg_write(4'd7, $urandom);
        reg_read(4'd7, rdata);
        check_value(rdata, 0, "unused register");

        // Transmit path with random divisor and stop setting
        cur_div      = 6 + ($urandom % 11);
        cur_two_stop = $urandom % 2;
        reg_write(UART_BAUD_R, cur_div);
        reg_write(UART_TXCTRL_R, cur_two_stop);
        for (int n = 0; n < 6; n++) begin
            wait_status_bit(ST_TX_READY, 1'b1);
            tx_byte = $urandom;
            exp_tx.push_back(tx_byte);
            fork
                decode_txd_frame(got_byte);
                begin
                    reg_write(UART_TXDATA_R, tx_byte);
                    reg_read(UART_STATUS_R, rdata);
                    check_value(rdata[ST_TX_READY], 0, "TX ready right after a write");
                    // Written while busy, must never reach the line
                    reg_write(UART_TXDATA_R, $urandom);
                end
            join
            check_value(got_byte, exp_tx.pop_front(), "TX byte");
        end
        wait_status_bit(ST_TX_READY, 1'b1);
        for (int i = 0; i < 12 * cur_div; i++) begin
            @(negedge clk);
            check_value(uart_txd, 1, "idle TX line");
        end

        // Receive path enabled, then disabled
        reg_write(UART_RXCTRL_R, 1);
        for (int n = 0; n < 5; n++) begin
            rx_byte = $urandom;
            exp_rx.push_back(rx_byte);
            send_rx_frame(rx_byte, 1'b1);
        end
        drain_rx_fifo();
        reg_write(UART_RXCTRL_R, 0);
        send_rx_frame($urandom, 1'b1);
        reg_read(UART_STATUS_R, rdata);
        check_value(rdata, 32'h1, "STATUS with receive disabled");

        // Overflow with nine frames
        reg_write(UART_RXCTRL_R, 1);
        for (int n = 0; n < 9; n++) begin
            rx_byte = $urandom;
            if (n < RX_FIFO_DEPTH) begin
                exp_rx.push_back(rx_byte);
            end
            send_rx_frame(rx_byte, 1'b1);
        end
        reg_read(UART_STATUS_R, rdata);
        check_value(rdata, 32'hb, "STATUS after overflow");
        reg_read(UART_STATUS_R, rdata);
        check_value(rdata, 32'h3, "STATUS after clearing read");
        drain_rx_fifo();

        // Framing error and interrupt
        reg_write(UART_INT_MASK_R, 32'h4);
        reg_read(UART_INT_MASK_R, rdata);
        check_value(rdata, 32'h4, "INT_MASK readback");
        check_value(uart_irq, 0, "irq before the bad frame");
        send_rx_frame($urandom, 1'b0);
        wait_irq(1'b1);
        reg_read(UART_STATUS_R, rdata);
        check_value(rdata, 32'h5, "STATUS after framing error");
        wait_irq(1'b0);
        reg_read(UART_RXDATA_R, rdata);
        check_value(rdata[31], 1, "RXDATA empty after framing error");

        if (uart_top_inst.uart_top_sva_inst.fail_cnt != 0) begin
            abort_run("A bound assertion on the UART failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb/uart_top_sva.sv */
// ------------------------------
// UART assertions
// Bus ack pulse, idle TX line, masked interrupt
// ------------------------------
`default_nettype none

module uart_top_sva (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           bus_ack_i,
    input logic                           txd_i,
    input logic                           irq_i,
    input uart_pkg::tx_state_e            tx_state_i,
    input logic [uart_pkg::STATUS_W-1:0]  int_mask_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import uart_pkg::*;

    // Number of failed assertions
    int unsigned fail_cnt;

    initial begin
        fail_cnt = 0;
    end

    // Ack is a single-cycle pulse
    ack_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) bus_ack_i |=> !bus_ack_i
    ) else begin
        $error("bus ack stayed high for two cycles");
        fail_cnt = fail_cnt + 1;
    end

    tx_idle_high: assert property (
        @(posedge clk) disable iff (!rst_n) (tx_state_i == TX_IDLE) |-> txd_i
    ) else begin
        $error("TX line low while the transmitter is idle");
        fail_cnt = fail_cnt + 1;
    end

    // Interrupt is registered, so the mask must be zero for two cycles
    irq_masked: assert property (
        @(posedge clk) disable iff (!rst_n)
        (int_mask_i == '0 && $past(int_mask_i) == '0) |-> !irq_i
    ) else begin
        $error("interrupt raised with a zero mask");
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind uart_top uart_top_sva uart_top_sva_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus_ack_i  (bus_ack_o),
    .txd_i      (uart_txd_o),
    .irq_i      (uart_irq_o),
    .tx_state_i (uart_tx_inst.state),
    .int_mask_i (uart_regs_inst.int_mask_q)
);

`default_nettype wire

/* uart/uart_regs.sv */
// ------------------------------
// UART register block
// Bus slave with register file, sticky status
// and the masked interrupt
// ------------------------------
`default_nettype none

module uart_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 bus_req_i,
    input  logic                 bus_we_i,
    input  logic [5:0]           bus_addr_i,
    input  uart_pkg::xlen_t      bus_wdata_i,
    input  logic                 uart_sel_i,
    output uart_pkg::xlen_t      bus_rdata_o,
    output logic                 bus_ack_o,
    uart_tx_if.ctrl              tx_if,
    input  uart_pkg::uart_byte_t rx_data_i,
    input  logic                 rx_valid_i,
    input  logic                 frame_err_i,
    output logic                 fifo_push_o,
    output uart_pkg::uart_byte_t fifo_push_data_o,
    output logic                 fifo_pop_o,
    input  uart_pkg::uart_byte_t fifo_head_i,
    input  logic                 fifo_empty_i,
    input  logic                 fifo_ovfl_i,
    output logic                 uart_irq_o
);
    import uart_pkg::*;

    reg_idx_t              idx;
    logic                  accept;
    logic                  rd_acc;
    logic                  wr_acc;
    logic                  status_rd;
    logic                  ack_q;
    xlen_t                 rdata_q;
    xlen_t                 rd_mux;

    baud_div_t             baud_q;
    logic                  two_stop_q;
    logic                  rx_en_q;
    logic [STATUS_W-1:0]   int_mask_q;
    logic                  frame_err_q;
    logic                  ovfl_q;
    logic [STATUS_W-1:0]   status;
    uart_byte_t            tx_data_q;
    logic                  tx_valid_q;
    logic                  irq_q;

    // ------------------------------
    // Access decode
    // ------------------------------
    assign idx       = reg_idx_t'(bus_addr_i[5:2]);
    // No new access in the ack cycle, so a held request is served once
    assign accept    = bus_req_i & uart_sel_i & ~ack_q;
    assign rd_acc    = accept & ~bus_we_i;
    assign wr_acc    = accept & bus_we_i;
    assign status_rd = rd_acc & (idx == UART_STATUS_R);

    always_comb begin
        status               = '0;
        status[ST_TX_READY]  = tx_if.tx_ready;
        status[ST_RX_AVAIL]  = ~fifo_empty_i;
        status[ST_FRAME_ERR] = frame_err_q;
        status[ST_RX_OVFL]   = ovfl_q;
    end

    // Read data mux, unused indices read as zero
    always_comb begin
        rd_mux = '0;
        case (idx)
            UART_TXDATA_R: rd_mux[XLEN-1] = ~tx_if.tx_ready;
            UART_RXDATA_R: begin
                rd_mux[XLEN-1]     = fifo_empty_i;
                rd_mux[BYTE_W-1:0] = fifo_head_i;
            end
            UART_BAUD_R:     rd_mux[BAUD_W-1:0]   = baud_q;
            UART_STATUS_R:   rd_mux[STATUS_W-1:0] = status;
            UART_TXCTRL_R:   rd_mux[0]            = two_stop_q;
            UART_RXCTRL_R:   rd_mux[0]            = rx_en_q;
            UART_INT_MASK_R: rd_mux[STATUS_W-1:0] = int_mask_q;
            default:         rd_mux               = '0;
        endcase
    end

    // ------------------------------
    // Bus response
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rdata_q <= rd_mux;
        end
    end

    // ------------------------------
    // Writable registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            baud_q     <= BAUD_RESET;
            two_stop_q <= 1'b0;
            rx_en_q    <= 1'b0;
            int_mask_q <= '0;
            tx_valid_q <= 1'b0;
        end else begin
            // Byte is dropped while the transmitter is busy
            tx_valid_q <= wr_acc & (idx == UART_TXDATA_R) & tx_if.tx_ready;
            if (wr_acc) begin
                case (idx)
                    UART_BAUD_R:     baud_q     <= bus_wdata_i[BAUD_W-1:0];
                    UART_TXCTRL_R:   two_stop_q <= bus_wdata_i[0];
                    UART_RXCTRL_R:   rx_en_q    <= bus_wdata_i[0];
                    UART_INT_MASK_R: int_mask_q <= bus_wdata_i[STATUS_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc && idx == UART_TXDATA_R) begin
            tx_data_q <= bus_wdata_i[BYTE_W-1:0];
        end
    end

    // Sticky errors, a new event wins over the clearing read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_err_q <= 1'b0;
            ovfl_q      <= 1'b0;
            irq_q       <= 1'b0;
        end else begin
            frame_err_q <= (frame_err_q & ~status_rd) | frame_err_i;
            ovfl_q      <= (ovfl_q & ~status_rd) | fifo_ovfl_i;
            irq_q       <= |(status & int_mask_q);
        end
    end

    assign tx_if.tx_data    = tx_data_q;
    assign tx_if.tx_valid   = tx_valid_q;
    assign tx_if.baud_div   = baud_q;
    assign tx_if.two_stop   = two_stop_q;

    assign fifo_push_o      = rx_valid_i & rx_en_q;
    assign fifo_push_data_o = rx_data_i;
    assign fifo_pop_o       = rd_acc & (idx == UART_RXDATA_R) & ~fifo_empty_i;

    assign bus_ack_o        = ack_q;
    assign bus_rdata_o      = rdata_q;
    assign uart_irq_o       = irq_q;

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
// ------------------------------
// UART receiver
// Mid-bit sampling with framing check
// ------------------------------
`default_nettype none

module uart_rx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rxd_i,
    input  uart_pkg::baud_div_t  baud_div_i,
    output uart_pkg::uart_byte_t rx_data_o,
    output logic                 rx_valid_o,
    output logic                 frame_err_o
);
    import uart_pkg::*;

    rx_state_e   state;
    logic        rxd_meta;
    logic        rxd_s;
    logic        rxd_prev;
    logic        fall;
    baud_div_t   cnt;
    logic [2:0]  bit_cnt;
    uart_byte_t  shift_q;
    logic        rx_valid_q;
    logic        frame_err_q;
    logic        half_end;
    logic        bit_end;

    // Two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_s    <= rxd_meta;
            rxd_prev <= rxd_s;
        end
    end

    assign fall     = rxd_prev & ~rxd_s;
    assign half_end = (cnt == baud_div_t'((baud_div_i >> 1) - 1'b1));
    assign bit_end  = (cnt == baud_div_t'(baud_div_i - 1'b1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= RX_IDLE;
            cnt         <= '0;
            bit_cnt     <= '0;
            rx_valid_q  <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            rx_valid_q  <= 1'b0;
            frame_err_q <= 1'b0;
            cnt         <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Middle of the start bit, a glitch returns to idle
                    if (half_end) begin
                        cnt     <= '0;
                        bit_cnt <= '0;
                        state   <= rxd_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        shift_q <= {rxd_s, shift_q[BYTE_W-1:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        rx_valid_q  <= rxd_s;
                        frame_err_q <= ~rxd_s;
                        state       <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    assign rx_data_o   = shift_q;
    assign rx_valid_o  = rx_valid_q;
    assign frame_err_o = frame_err_q;

endmodule

`default_nettype wire

/* uart/uart_rx_fifo.sv */
// ------------------------------
// Receive FIFO
// Circular buffer with overflow pulse
// ------------------------------
`default_nettype none

module uart_rx_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push_i,
    input  uart_pkg::uart_byte_t push_data_i,
    input  logic                 pop_i,
    output uart_pkg::uart_byte_t head_o,
    output logic                 empty_o,
    output logic                 ovfl_o
);
    import uart_pkg::*;

    uart_byte_t             mem [RX_FIFO_DEPTH];
    logic [RX_FIFO_AW-1:0]  wr_ptr;
    logic [RX_FIFO_AW-1:0]  rd_ptr;
    logic [RX_FIFO_AW:0]    count;
    logic                   full;
    logic                   do_push;
    logic                   do_pop;
    logic                   ovfl_q;

    assign full    = (count == RX_FIFO_DEPTH);
    assign do_pop  = pop_i & ~empty_o;
    // A full FIFO still takes a push when it pops in the same cycle
    assign do_push = push_i & (~full | do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovfl_q <= 1'b0;
        end else begin
            ovfl_q <= push_i & ~do_push;
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_o  = mem[rd_ptr];
    assign empty_o = (count == '0);
    assign ovfl_o  = ovfl_q;

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
// ------------------------------
// UART transmitter
// Start bit, 8 data bits LSB first, 1 or 2 stop bits
// ------------------------------
`default_nettype none

module uart_tx (
    input  logic    clk,
    input  logic    rst_n,
    uart_tx_if.ser  tx_if,
    output logic    txd_o
);
    import uart_pkg::*;

    tx_state_e   state;
    baud_div_t   baud_cnt;
    logic [2:0]  bit_cnt;
    uart_byte_t  shift_q;
    logic        txd_q;
    logic        bit_end;

    assign bit_end = (baud_cnt == baud_div_t'(tx_if.baud_div - 1'b1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            txd_q    <= 1'b1;
        end else begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    baud_cnt <= '0;
                    if (tx_if.tx_valid) begin
                        shift_q <= tx_if.tx_data;
                        txd_q   <= 1'b0;
                        state   <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        txd_q   <= shift_q[0];
                        bit_cnt <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        shift_q <= shift_q >> 1;
                        bit_cnt <= bit_cnt + 1'b1;
                        txd_q   <= shift_q[1];
                        if (bit_cnt == 3'd7) begin
                            txd_q   <= 1'b1;
                            bit_cnt <= '0;
                            state   <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    // bit_cnt marks the second stop bit
                    if (bit_end) begin
                        if (tx_if.two_stop && bit_cnt == 3'd0) begin
                            bit_cnt <= 3'd1;
                        end else begin
                            state <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    assign tx_if.tx_ready = (state == TX_IDLE);
    assign txd_o          = txd_q;

endmodule

`default_nettype wire

/* vlog.f */
common/uart_pkg.sv
common/uart_tx_if.sv
uart/uart_rx_fifo.sv
uart/uart_rx.sv
uart/uart_tx.sv
uart/uart_regs.sv
source/uart_top.sv
tb/uart_top_sva.sv
tb/tb_uart_top.sv
